// ==== src/arbiter_pkg.sv ====
// --------------------------------------------------
// Widths, client count, rank table and FSM encodings
// for the fixed-priority bus arbiter
// --------------------------------------------------
package arbiter_pkg;

    localparam int n_clients   = 4;
    localparam int client_id_w = 2;
    localparam int addr_w      = 4;
    localparam int data_w      = 8;

    typedef logic [addr_w-1:0]    addr_t;
    typedef logic [data_w-1:0]    data_t;
    typedef logic [n_clients-1:0] client_mask_t;

    // Rank 0 is served first
    localparam logic [n_clients-1:0][client_id_w-1:0] client_rank = {2'd3, 2'd2, 2'd1, 2'd0};

    // Client port holder states
    localparam logic [1:0] port_empty = 2'd0;
    localparam logic [1:0] port_wait  = 2'd1;
    localparam logic [1:0] port_resp  = 2'd2;

    // Server port states
    localparam logic [1:0] srv_st_idle = 2'd0;
    localparam logic [1:0] srv_st_req  = 2'd1;
    localparam logic [1:0] srv_st_fin  = 2'd2;

endpackage

// ==== src/client_link_if.sv ====
// --------------------------------------------------
// Link between one client port, the grant arbiter
// and the server port
// --------------------------------------------------
interface client_link_if
    import arbiter_pkg::*;
();
    // Request held by the client port
    logic  pending;
    addr_t addr;
    logic  wr;
    data_t wdata;

    logic  grant;

    // One-cycle completion with read data
    logic  done;
    data_t rdata;

    modport port (
        output pending,
        output addr,
        output wr,
        output wdata,
        input  done,
        input  rdata
    );

    modport arb (
        input  pending,
        input  done,
        output grant
    );

    modport srv (
        input  grant,
        input  addr,
        input  wr,
        input  wdata,
        output done,
        output rdata
    );

endinterface

// ==== src/client_port.sv ====
// --------------------------------------------------
// Per-client request and response holder
// --------------------------------------------------
module client_port
    import arbiter_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        req_valid,
    input  logic        req_wr,
    input  addr_t       req_addr,
    input  data_t       req_wdata,
    output logic        req_ready,
    output logic        rsp_valid,
    input  logic        rsp_ready,
    output data_t       rsp_rdata,
    client_link_if.port link
);

    logic [1:0] state_q;
    logic [1:0] state_d;
    logic       accept;
    addr_t      addr_q;
    logic       wr_q;
    data_t      wdata_q;
    data_t      rdata_q;

    assign accept = req_valid && req_ready;

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            port_empty:
                if (accept)
                    state_d = port_wait;
            port_wait:
                if (link.done)
                    state_d = port_resp;
            port_resp:
                if (rsp_ready)
                    state_d = port_empty;
            default:
                state_d = port_empty;
        endcase
    end

    // Ready is registered so it stays low through reset
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state_q   <= port_empty;
            req_ready <= 1'b0;
        end
        else
        begin
            state_q   <= state_d;
            req_ready <= (state_d == port_empty);
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            addr_q  <= req_addr;
            wr_q    <= req_wr;
            wdata_q <= req_wdata;
        end
        if (state_q == port_wait && link.done)
            rdata_q <= link.rdata;
    end

    assign link.pending = (state_q == port_wait);
    assign link.addr    = addr_q;
    assign link.wr      = wr_q;
    assign link.wdata   = wdata_q;

    assign rsp_valid = (state_q == port_resp);
    assign rsp_rdata = rdata_q;

endmodule

// ==== src/grant_arbiter.sv ====
// --------------------------------------------------
// Fixed-priority grant over the client links
// --------------------------------------------------
module grant_arbiter
    import arbiter_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    client_link_if.arb links [n_clients]
);

    client_mask_t pending;
    client_mask_t done;
    client_mask_t grant_q;
    client_mask_t pick;

    for (genvar i = 0; i < n_clients; i++)
    begin : g_link
        assign pending[i]     = links[i].pending;
        assign done[i]        = links[i].done;
        assign links[i].grant = grant_q[i];
    end

    // Walk ranks from highest priority down, first pending client wins
    always_comb
    begin
        pick = '0;
        for (int r = 0; r < n_clients; r++)
        begin
            for (int c = 0; c < n_clients; c++)
            begin
                if (pick == '0 && pending[c] && client_rank[c] == client_id_w'(r))
                    pick[c] = 1'b1;
            end
        end
    end

    // Grant is held until its link reports done
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            grant_q <= '0;
        else if (grant_q == '0)
            grant_q <= pick;
        else if ((grant_q & done) != '0)
            grant_q <= '0;
    end

endmodule

// ==== src/server_port.sv ====
// --------------------------------------------------
// Server bus master for the granted client link
// --------------------------------------------------
module server_port
    import arbiter_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    client_link_if.srv links [n_clients],
    output logic       srv_rq,
    output logic       srv_wr,
    output addr_t      srv_addr,
    output data_t      srv_wdata,
    input  logic       srv_ack,
    input  data_t      srv_rdata
);

    client_mask_t grant;
    client_mask_t link_wr;
    addr_t        link_addr  [n_clients];
    data_t        link_wdata [n_clients];
    addr_t        sel_addr;
    logic         sel_wr;
    data_t        sel_wdata;
    logic [1:0]   state_q;
    client_mask_t owner_q;
    client_mask_t done_q;
    data_t        rdata_q;
    logic         start;

    for (genvar i = 0; i < n_clients; i++)
    begin : g_link
        assign grant[i]      = links[i].grant;
        assign link_addr[i]  = links[i].addr;
        assign link_wr[i]    = links[i].wr;
        assign link_wdata[i] = links[i].wdata;

        // Only the owner sees the completion and its data
        assign links[i].done  = done_q[i];
        assign links[i].rdata = done_q[i] ? rdata_q : '0;
    end

    // Grant is one-hot, so a plain OR-style select is enough
    always_comb
    begin
        sel_addr  = '0;
        sel_wr    = 1'b0;
        sel_wdata = '0;
        for (int i = 0; i < n_clients; i++)
        begin
            if (grant[i])
            begin
                sel_addr  = link_addr[i];
                sel_wr    = link_wr[i];
                sel_wdata = link_wdata[i];
            end
        end
    end

    assign start = (state_q == srv_st_idle) && (grant != '0);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state_q <= srv_st_idle;
            srv_rq  <= 1'b0;
            owner_q <= '0;
            done_q  <= '0;
        end
        else
        begin
            case (state_q)
                srv_st_idle:
                    if (start)
                    begin
                        srv_rq  <= 1'b1;
                        owner_q <= grant;
                        state_q <= srv_st_req;
                    end
                srv_st_req:
                    if (srv_ack)
                    begin
                        srv_rq  <= 1'b0;
                        done_q  <= owner_q;
                        state_q <= srv_st_fin;
                    end
                srv_st_fin:
                begin
                    done_q <= '0;
                    // Wait for the arbiter to drop the grant
                    if ((grant & owner_q) == '0)
                        state_q <= srv_st_idle;
                end
                default:
                    state_q <= srv_st_idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            srv_addr  <= sel_addr;
            srv_wr    <= sel_wr;
            srv_wdata <= sel_wdata;
        end
        if (state_q == srv_st_req && srv_ack)
            rdata_q <= srv_rdata;
    end

endmodule

// ==== src/bus_arbiter_top.sv ====
// --------------------------------------------------
// Four-client fixed-priority bus arbiter top level
// --------------------------------------------------
module bus_arbiter_top
    import arbiter_pkg::*;
(
    input  logic         clk,
    input  logic         reset,

    // Client request channels
    input  client_mask_t client_req_valid,
    input  client_mask_t client_req_wr,
    input  addr_t        client_req_addr  [n_clients],
    input  data_t        client_req_wdata [n_clients],
    output client_mask_t client_req_ready,

    // Client response channels
    output client_mask_t client_rsp_valid,
    input  client_mask_t client_rsp_ready,
    output data_t        client_rsp_rdata [n_clients],

    // Server bus
    output logic         srv_rq,
    input  logic         srv_ack,
    output addr_t        srv_addr,
    output logic         srv_wr,
    output data_t        srv_wdata,
    input  data_t        srv_rdata
);

    client_link_if links [n_clients] ();

    for (genvar i = 0; i < n_clients; i++)
    begin : g_client
        client_port u_port (
            .clk       (clk),
            .reset     (reset),
            .req_valid (client_req_valid[i]),
            .req_wr    (client_req_wr[i]),
            .req_addr  (client_req_addr[i]),
            .req_wdata (client_req_wdata[i]),
            .req_ready (client_req_ready[i]),
            .rsp_valid (client_rsp_valid[i]),
            .rsp_ready (client_rsp_ready[i]),
            .rsp_rdata (client_rsp_rdata[i]),
            .link      (links[i])
        );
    end

    grant_arbiter u_grant (
        .clk   (clk),
        .reset (reset),
        .links (links)
    );

    server_port u_server (
        .clk       (clk),
        .reset     (reset),
        .links     (links),
        .srv_rq    (srv_rq),
        .srv_wr    (srv_wr),
        .srv_addr  (srv_addr),
        .srv_wdata (srv_wdata),
        .srv_ack   (srv_ack),
        .srv_rdata (srv_rdata)
    );

endmodule

// ==== testbench/tb_common.svh ====
// --------------------------------------------------
// Seed, timing limits, LFSR source, value compare
// and timeout waits for the arbiter testbench
// --------------------------------------------------
`ifndef TB_COMMON_SVH
`define TB_COMMON_SVH

localparam logic [31:0] lfsr_seed  = 32'h0aee_e817;
localparam int          clk_period = 40;
localparam int          n_trans    = 400;
localparam int          wait_limit = 2000;
localparam int          run_limit  = 200000;

logic [31:0] lfsr_state = lfsr_seed;

// Galois LFSR, one step per bit taken
function automatic logic [31:0] take_bits(input int n);
    logic [31:0] value;
    value = '0;
    for (int k = 0; k < n; k++)
    begin
        value = {value[30:0], lfsr_state[0]};
        if (lfsr_state[0])
            lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
        else
            lfsr_state = lfsr_state >> 1;
    end
    return value;
endfunction

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (expected !== actual)
    begin
        $display("mismatch %s expected %0h actual %0h", name, expected, actual);
        $display("Done: errors found");
        $fatal(1, "stopped at first error");
    end
endtask

task automatic stop_on_failure(input string what);
    $display("%s", what);
    $display("Done: errors found");
    $fatal(1, "stopped at failure");
endtask

task automatic wait_idle(input int limit);
    int count;
    count = 0;
    @(negedge clk);
    while (!all_idle())
    begin
        count++;
        if (count > limit)
            stop_on_failure("timeout while waiting for all traffic to drain");
        @(negedge clk);
    end
endtask

`endif

// ==== testbench/tb_bus_arbiter.sv ====
// --------------------------------------------------
// Random clients, server model and scoreboard
// for the fixed-priority bus arbiter
// --------------------------------------------------
module tb_bus_arbiter
    import arbiter_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    logic         clk;
    logic         reset;
    client_mask_t req_valid;
    client_mask_t req_wr;
    addr_t        req_addr  [n_clients];
    data_t        req_wdata [n_clients];
    client_mask_t req_ready;
    client_mask_t rsp_valid;
    client_mask_t rsp_ready;
    data_t        rsp_rdata [n_clients];
    logic         srv_rq;
    logic         srv_ack;
    addr_t        srv_addr;
    logic         srv_wr;
    data_t        srv_wdata;
    data_t        srv_rdata;

    // Queued requests as {wr, addr, wdata} and results as {is_read, data}
    logic [12:0]  unserved_q [n_clients][$];
    logic [8:0]   result_q   [n_clients][$];
    int           served_order [$];
    data_t        srv_mem [16];
    data_t        ref_mem [16];
    client_mask_t held_valid;
    data_t        held_data [n_clients];
    logic         busy;
    logic         just_done;
    int           cur_client;
    logic [12:0]  cur_fields;
    int           delay;
    int           issued_total;
    int           issued_dir [n_clients];
    int           dir_count  [n_clients];
    logic         mode;
    logic         stall;

    `include "tb_common.svh"

    bus_arbiter_top u_dut (
        .clk              (clk),
        .reset            (reset),
        .client_req_valid (req_valid),
        .client_req_wr    (req_wr),
        .client_req_addr  (req_addr),
        .client_req_wdata (req_wdata),
        .client_req_ready (req_ready),
        .client_rsp_valid (rsp_valid),
        .client_rsp_ready (rsp_ready),
        .client_rsp_rdata (rsp_rdata),
        .srv_rq           (srv_rq),
        .srv_ack          (srv_ack),
        .srv_addr         (srv_addr),
        .srv_wr           (srv_wr),
        .srv_wdata        (srv_wdata),
        .srv_rdata        (srv_rdata)
    );

    function automatic logic all_idle();
        logic idle;
        idle = !busy && (req_valid == '0);
        for (int i = 0; i < n_clients; i++)
            if (unserved_q[i].size() != 0 || result_q[i].size() != 0)
                idle = 1'b0;
        return idle;
    endfunction

    initial
    begin
        clk = 1'b0;
        forever
            #(clk_period / 2) clk = ~clk;
    end

    // Server model, scoreboard and client drivers
    always @(posedge clk)
    begin : model
        logic [12:0] fields;
        logic [8:0]  result;
        int          best;
        if (!reset)
        begin
            if (just_done)
                check_value("srv_rq after ack", 0, srv_rq);
            just_done = 1'b0;
            if (busy && srv_ack)
            begin
                check_value("srv_rq at ack", 1, srv_rq);
                if (cur_fields[12])
                begin
                    srv_mem[cur_fields[11:8]] = cur_fields[7:0];
                    ref_mem[cur_fields[11:8]] = cur_fields[7:0];
                    result_q[cur_client].push_back(9'h0);
                end
                else
                    result_q[cur_client].push_back({1'b1, ref_mem[cur_fields[11:8]]});
                if (mode)
                    served_order.push_back(cur_client);
                srv_ack <= 1'b0;
                busy = 1'b0;
                just_done = 1'b1;
            end
            else
            begin
                if (!busy && srv_rq)
                begin
                    fields = {srv_wr, srv_addr, srv_wdata};
                    best = -1;
                    for (int r = 0; r < n_clients; r++)
                        for (int c = 0; c < n_clients; c++)
                            if (best < 0 && client_rank[c] == r && unserved_q[c].size() != 0
                                && unserved_q[c][0] == fields)
                                best = c;
                    if (best < 0)
                        stop_on_failure("server transaction matches no pending request");
                    void'(unserved_q[best].pop_front());
                    cur_client = best;
                    cur_fields = fields;
                    delay = int'(take_bits(2));
                    busy = 1'b1;
                end
                if (busy)
                begin
                    check_value("srv_rq held", 1, srv_rq);
                    check_value("server fields stable", cur_fields, {srv_wr, srv_addr, srv_wdata});
                    if (!stall)
                    begin
                        if (delay == 0)
                        begin
                            srv_ack   <= 1'b1;
                            srv_rdata <= srv_mem[srv_addr];
                        end
                        else
                            delay--;
                    end
                end
            end

            for (int i = 0; i < n_clients; i++)
            begin
                if (held_valid[i])
                begin
                    check_value("rsp_valid held", 1, rsp_valid[i]);
                    check_value("rsp_rdata held", held_data[i], rsp_rdata[i]);
                end
                if (rsp_valid[i])
                    check_value("req_ready during response", 0, req_ready[i]);
                if (rsp_valid[i] && rsp_ready[i])
                begin
                    if (result_q[i].size() == 0)
                        stop_on_failure("response arrived with no request served");
                    result = result_q[i].pop_front();
                    if (result[8])
                        check_value("read data", result[7:0], rsp_rdata[i]);
                end
                held_valid[i] = rsp_valid[i] && !rsp_ready[i];
                held_data[i]  = rsp_rdata[i];

                if (req_valid[i] && req_ready[i])
                    unserved_q[i].push_back({req_wr[i], req_addr[i], req_wdata[i]});
                if (!req_valid[i] || req_ready[i])
                begin
                    req_valid[i] <= 1'b0;
                    if (mode ? (issued_dir[i] < dir_count[i])
                             : (take_bits(1) == 1 && issued_total < n_trans))
                    begin
                        req_valid[i] <= 1'b1;
                        req_wr[i]    <= mode ? 1'b0 : take_bits(1) == 1;
                        req_addr[i]  <= addr_t'(take_bits(addr_w));
                        req_wdata[i] <= data_t'(take_bits(data_w));
                        if (mode)
                            issued_dir[i]++;
                        else
                            issued_total++;
                    end
                end
                rsp_ready[i] <= mode ? 1'b1 : take_bits(1) == 1;
            end
        end
    end

    initial
    begin : main
        int   count;
        int   first;
        int   k;
        logic loaded;
        reset      = 1'b1;
        req_valid  = '0;
        req_wr     = '0;
        rsp_ready  = '0;
        srv_ack    = 1'b0;
        srv_rdata  = '0;
        held_valid = '0;
        busy       = 1'b0;
        just_done  = 1'b0;
        mode       = 1'b0;
        stall      = 1'b0;
        issued_total = 0;
        for (int i = 0; i < n_clients; i++)
        begin
            req_addr[i]   = '0;
            req_wdata[i]  = '0;
            issued_dir[i] = 0;
            dir_count[i]  = 0;
        end
        for (int a = 0; a < 16; a++)
        begin
            srv_mem[a] = data_t'(a * 37 + 5);
            ref_mem[a] = data_t'(a * 37 + 5);
        end

        repeat (10)
        begin
            @(negedge clk);
            check_value("req_ready in reset", 0, req_ready);
            check_value("rsp_valid in reset", 0, rsp_valid);
            check_value("srv_rq in reset", 0, srv_rq);
        end
        @(posedge clk);
        reset <= 1'b0;
        count = 0;
        @(negedge clk);
        while (req_ready != '1)
        begin
            count++;
            if (count > wait_limit)
                stop_on_failure("req_ready did not rise after reset");
            @(negedge clk);
        end

        // Random traffic
        count = 0;
        while (issued_total < n_trans)
        begin
            count++;
            if (count > run_limit)
                stop_on_failure("timeout while issuing random requests");
            @(negedge clk);
        end
        wait_idle(wait_limit);

        // Priority check with the server stalled on the lowest-ranked client
        mode  = 1'b1;
        stall = 1'b1;
        first = 0;
        for (int c = 0; c < n_clients; c++)
            if (client_rank[c] > client_rank[first])
                first = c;
        dir_count[first] = 1;
        count = 0;
        @(negedge clk);
        while (!busy)
        begin
            count++;
            if (count > wait_limit)
                stop_on_failure("stalled transaction never started");
            @(negedge clk);
        end
        for (int c = 0; c < n_clients; c++)
            if (c != first)
                dir_count[c] = 1;

        // Hold the stall until every other client has a request accepted
        count  = 0;
        loaded = 1'b0;
        while (!loaded)
        begin
            @(negedge clk);
            loaded = 1'b1;
            for (int c = 0; c < n_clients; c++)
                if (c != first && unserved_q[c].size() == 0)
                    loaded = 1'b0;
            count++;
            if (!loaded && count > wait_limit)
                stop_on_failure("other clients were not accepted during the stall");
        end
        stall = 1'b0;
        wait_idle(wait_limit);

        k = 1;
        for (int r = 0; r < n_clients; r++)
            for (int c = 0; c < n_clients; c++)
                if (c != first && client_rank[c] == r)
                begin
                    check_value("priority order", c, served_order[k]);
                    k++;
                end

        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+testbench
src/arbiter_pkg.sv
src/client_link_if.sv
src/client_port.sv
src/grant_arbiter.sv
src/server_port.sv
src/bus_arbiter_top.sv
testbench/tb_bus_arbiter.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the arbiter testbench with Verilator
rm -f sim.log
verilator --binary --timing -f build.f --top-module tb_bus_arbiter -o sim_tb > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 || true
grep -q "Done: no errors" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
